// ==== sources.f ====
source/flash_ctrl_pkg.sv
source/flash_request_regs.sv
source/flash_sequencer.sv
source/flash_shifter.sv
source/flash_controller.sv
testbench/flash_controller_properties.sv
testbench/flash_controller_tb.sv

// ==== Makefile ====
# Verilator build and run for the flash controller testbench

TOP       ?= flash_controller_tb
LOG       ?= sim.log
TRACE     ?=
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
SIM_ARGS  ?= +verilator+error+limit+100

VFLAGS = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR) $(TRACE)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: TOP, LOG, TRACE (for example TRACE=--trace), OBJ_DIR, SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) -f sources.f
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/flash_controller_tb.sv ====
`timescale 1ns/10ps

module flash_controller_tb;

    localparam int          sck_div     = 2;
    localparam int          num_trans   = 10;
    localparam int          cycle_limit = num_trans * 100 * 2 * sck_div + 1000;
    localparam logic [31:0] lfsr_seed   = 32'd50;
    localparam logic [31:0] xor_pattern = 32'hA5A55A5A;
    localparam int          busy_polls  = 3;   // Status reads with WIP set

    logic        i_clk = 1'b0;
    logic        i_reset;
    logic        start;
    logic        cont;
    logic        quad;
    logic        write;
    logic [23:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rd_valid;
    logic        wr_done;
    logic        busy;
    logic        cs_n;
    logic        sck;
    logic [3:0]  dq_out;
    logic [3:0]  dq_oe;
    logic [3:0]  dq_in = 4'h0;

    // Flash model state
    logic [31:0] prog_mem [logic [23:0]];
    logic        sck_prev   = 1'b0;
    logic        cs_prev    = 1'b1;
    int          rise_cnt   = 0;
    logic [7:0]  m_cmd      = 8'h00;
    logic [23:0] m_addr     = 24'h0;
    logic [31:0] m_data     = 32'h0;
    logic        wel        = 1'b0;
    int          polls_left = 0;

    logic [31:0] lfsr_state = lfsr_seed;
    int          cycles     = 0;

    always #2 i_clk = ~i_clk;

    flash_controller #(
        .sck_div (sck_div)
    ) uut (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .start    (start),
        .cont     (cont),
        .quad     (quad),
        .write    (write),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .rd_valid (rd_valid),
        .wr_done  (wr_done),
        .busy     (busy),
        .cs_n     (cs_n),
        .sck      (sck),
        .dq_out   (dq_out),
        .dq_oe    (dq_oe),
        .dq_in    (dq_in)
    );

    bind flash_controller flash_controller_properties u_props (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .start    (start),
        .cont     (cont),
        .busy     (busy),
        .rd_valid (rd_valid),
        .wr_done  (wr_done),
        .cs_n     (cs_n),
        .sck      (sck),
        .dq_oe    (dq_oe)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            stop_with_failure($sformatf("Fail: %s = %h, expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] erased_word(input logic [23:0] a);
        return {8'h00, a} ^ xor_pattern;
    endfunction

    function automatic logic [31:0] flash_word(input logic [23:0] a);
        if (prog_mem.exists(a)) begin
            return prog_mem[a];
        end
        return erased_word(a);
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    //////////////////////////////////////////////////
    // Flash model, SPI mode 0, sampled on the falling system clock

    task automatic sample_rise();
        rise_cnt++;
        if (rise_cnt <= 8) begin
            m_cmd = {m_cmd[6:0], dq_out[0]};
        end else if (rise_cnt <= 32) begin
            m_addr = {m_addr[22:0], dq_out[0]};
        end else if (m_cmd == 8'h02 && rise_cnt <= 64) begin
            m_data = {m_data[30:0], dq_out[0]};
        end
        if (rise_cnt <= 8) begin
            check_value("dq_oe", 32'(dq_oe), 32'hD);   // Opcode goes out on one lane
            check_value("dq_out[3:2]", 32'(dq_out[3:2]), 32'h3);   // WP and HOLD high
        end
        if (m_cmd == 8'h6B && rise_cnt > 40) begin
            check_value("dq_oe", 32'(dq_oe), 32'h0);   // Quad data lanes released
        end
        if (m_cmd == 8'h03 && rise_cnt > 32) begin
            check_value("dq_oe[1]", 32'(dq_oe[1]), 32'h0);
        end
    endtask

    task automatic drive_fall();
        int          idx;
        logic [31:0] w;
        if (m_cmd == 8'h03 && rise_cnt >= 32) begin
            idx   = rise_cnt - 32;
            w     = flash_word(m_addr + 24'(4 * (idx / 32)));
            dq_in = {2'b00, w[31 - idx % 32], 1'b0};
        end else if (m_cmd == 8'h6B && rise_cnt >= 40) begin
            idx   = rise_cnt - 40;   // After 8 dummy clocks
            w     = flash_word(m_addr + 24'(4 * (idx / 8)));
            dq_in = w[4 * (7 - idx % 8) +: 4];
        end else if (m_cmd == 8'h05 && rise_cnt >= 8) begin
            idx   = rise_cnt - 8;
            dq_in = {2'b00, (idx % 8 == 7) && (polls_left != 0), 1'b0};
        end
    endtask

    task automatic end_transaction();
        if (m_cmd == 8'h06 && rise_cnt == 8) begin
            wel = 1'b1;
        end else if (m_cmd == 8'h02 && rise_cnt == 64 && wel) begin
            prog_mem[m_addr] = m_data;
            wel              = 1'b0;
            polls_left       = busy_polls;
        end else if (m_cmd == 8'h05 && rise_cnt >= 16 && polls_left > 0) begin
            polls_left--;
        end
    endtask

    always @(negedge i_clk) begin
        if (cs_n) begin
            if (!cs_prev) begin
                end_transaction();
            end
            rise_cnt = 0;
            dq_in    = 4'h0;
        end else if (sck && !sck_prev) begin
            sample_rise();
        end else if (!sck && sck_prev) begin
            drive_fall();
        end
        sck_prev = sck;
        cs_prev  = cs_n;
    end

    // Watchdog and concurrent check monitor
    always @(negedge i_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            stop_with_failure($sformatf("Timeout: run did not finish in %0d cycles", cycles));
        end else if (uut.u_props.fail_count != 0) begin
            stop_with_failure("A protocol check on the flash pins failed");
        end
    end

    //////////////////////////////////////////////////
    // Host side

    task automatic send_request(input logic wr, input logic qd, input logic [23:0] a,
                                input logic [31:0] d);
        @(negedge i_clk);
        write = wr;
        quad  = qd;
        addr  = a;
        wdata = d;
        start = 1'b1;
        @(negedge i_clk);
        start = 1'b0;
    endtask

    task automatic expect_read(input logic [31:0] exp);
        @(negedge i_clk);
        while (!rd_valid) begin
            @(negedge i_clk);
        end
        check_value("rdata", rdata, exp);
    endtask

    task automatic wait_wr_done();
        @(negedge i_clk);
        while (!wr_done) begin
            @(negedge i_clk);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [23:0] a;
        logic [23:0] other;
        i_reset = 1'b1;
        start   = 1'b0;
        cont    = 1'b0;
        quad    = 1'b0;
        write   = 1'b0;
        addr    = 24'h0;
        wdata   = 32'h0;
        repeat (2) @(negedge i_clk);
        i_reset = 1'b0;
        repeat (6) @(negedge i_clk);

        // Single read
        take_bits(22, r);
        a = {r[21:0], 2'b00};
        send_request(1'b0, 1'b0, a, 32'h0);
        expect_read(erased_word(a));

        // Continuous read of three words
        take_bits(22, r);
        a    = {r[21:0], 2'b00};
        cont = 1'b1;
        send_request(1'b0, 1'b0, a, 32'h0);
        expect_read(erased_word(a));
        expect_read(erased_word(a + 24'd4));
        cont = 1'b0;
        expect_read(erased_word(a + 24'd8));

        // Quad read
        take_bits(22, r);
        a = {r[21:0], 2'b00};
        send_request(1'b0, 1'b1, a, 32'h0);
        expect_read(erased_word(a));
        quad = 1'b0;

        // Program then read back
        take_bits(22, r);
        a = {r[21:0], 2'b00};
        take_bits(32, d);
        take_bits(22, r);
        other = {r[21:0], 2'b00};
        send_request(1'b1, 1'b0, a, d);
        repeat (6) @(negedge i_clk);
        check_value("busy", 32'(busy), 32'h1);
        // Dropped, else the program would go to the other word
        send_request(1'b1, 1'b0, other, ~d);
        wait_wr_done();
        check_value("busy", 32'(busy), 32'h0);
        send_request(1'b0, 1'b0, a, 32'h0);
        expect_read(d);

        repeat (10) @(negedge i_clk);
        if (uut.u_props.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_with_failure("A protocol check on the flash pins failed");
        end
    end

endmodule

// ==== testbench/flash_controller_properties.sv ====
`timescale 1ns/10ps

module flash_controller_properties (
    input logic       i_clk,
    input logic       i_reset,
    input logic       start,
    input logic       cont,
    input logic       busy,
    input logic       rd_valid,
    input logic       wr_done,
    input logic       cs_n,
    input logic       sck,
    input logic [3:0] dq_oe
);

    int unsigned fail_count = 0;

    //////////////////////////////////////////////////
    // Pins and strobes

    reset_idle: assert property (@(posedge i_clk)
        $past(i_reset) |-> cs_n && !sck && dq_oe == 4'h0 && !busy && !rd_valid && !wr_done)
    else begin
        $error("Fail: after reset cs_n = %h sck = %h dq_oe = %h busy = %h",
               cs_n, sck, dq_oe, busy);
        fail_count++;
    end

    idle_pins: assert property (@(posedge i_clk) disable iff (i_reset)
        !busy |-> cs_n && !sck && dq_oe == 4'h0)
    else begin
        $error("Fail: idle cs_n = %h sck = %h dq_oe = %h", cs_n, sck, dq_oe);
        fail_count++;
    end

    // Request latched, then req_load, then busy
    busy_needs_start: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(busy) |-> $past(start, 2) && !$past(busy, 2))
    else begin
        $error("busy rose without an accepted start two cycles earlier");
        fail_count++;
    end

    sck_low_when_deselected: assert property (@(posedge i_clk) disable iff (i_reset)
        cs_n |-> !sck)
    else begin
        $error("Fail: sck = %h while cs_n = %h", sck, cs_n);
        fail_count++;
    end

    pulse_inside_transaction: assert property (@(posedge i_clk) disable iff (i_reset)
        (rd_valid || wr_done) |-> $past(busy))
    else begin
        $error("Fail: strobe with busy low, rd_valid = %h wr_done = %h", rd_valid, wr_done);
        fail_count++;
    end

    // wr_done lines up with the end of busy
    wr_done_at_busy_fall: assert property (@(posedge i_clk) disable iff (i_reset)
        wr_done |-> $fell(busy))
    else begin
        $error("Fail: wr_done = %h with busy = %h", wr_done, busy);
        fail_count++;
    end

    busy_fall_has_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(busy) |-> rd_valid || wr_done)
    else begin
        $error("Fail: busy fell with rd_valid = %h wr_done = %h", rd_valid, wr_done);
        fail_count++;
    end

    cont_keeps_cs_low: assert property (@(posedge i_clk) disable iff (i_reset)
        rd_valid && $past(cont) |-> !cs_n && busy)
    else begin
        $error("Fail: cs_n = %h between words of a continuous read", cs_n);
        fail_count++;
    end

endmodule

// ==== source/flash_controller.sv ====
`timescale 1ns/10ps

module flash_controller #(
    parameter int sck_div = 4
) (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  logic                               start,
    input  logic                               cont,
    input  logic                               quad,
    input  logic                               write,
    input  logic [flash_ctrl_pkg::addr_w-1:0]  addr,
    input  logic [flash_ctrl_pkg::word_w-1:0]  wdata,
    output logic [flash_ctrl_pkg::word_w-1:0]  rdata,
    output logic                               rd_valid,
    output logic                               wr_done,
    output logic                               busy,
    output logic                               cs_n,
    output logic                               sck,
    output logic [3:0]                         dq_out,
    output logic [3:0]                         dq_oe,
    input  logic [3:0]                         dq_in
);

    flash_ctrl_pkg::flash_req_t        req;
    flash_ctrl_pkg::shift_job_t        job;
    logic                              req_load;
    logic                              next_word;
    logic                              job_go;
    logic                              job_done;
    logic [flash_ctrl_pkg::word_w-1:0] rx_data;

    flash_request_regs u_request_regs (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .start     (start),
        .quad      (quad),
        .write     (write),
        .addr      (addr),
        .wdata     (wdata),
        .busy      (busy),
        .next_word (next_word),
        .req       (req),
        .req_load  (req_load)
    );

    flash_sequencer u_sequencer (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .req       (req),
        .req_load  (req_load),
        .cont      (cont),
        .job_done  (job_done),
        .rx_data   (rx_data),
        .job       (job),
        .job_go    (job_go),
        .cs_n      (cs_n),
        .next_word (next_word),
        .rdata     (rdata),
        .rd_valid  (rd_valid),
        .wr_done   (wr_done),
        .busy      (busy)
    );

    flash_shifter #(
        .sck_div (sck_div)
    ) u_shifter (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .job      (job),
        .job_go   (job_go),
        .dq_in    (dq_in),
        .job_done (job_done),
        .rx_data  (rx_data),
        .sck      (sck),
        .dq_out   (dq_out),
        .dq_oe    (dq_oe)
    );

endmodule

// ==== source/flash_shifter.sv ====
`timescale 1ns/10ps

module flash_shifter #(
    parameter int sck_div = 2
) (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  flash_ctrl_pkg::shift_job_t         job,
    input  logic                               job_go,
    input  logic [3:0]                         dq_in,
    output logic                               job_done,
    output logic [flash_ctrl_pkg::word_w-1:0]  rx_data,
    output logic                               sck,
    output logic [3:0]                         dq_out,
    output logic [3:0]                         dq_oe
);

    localparam int presc_w = (sck_div > 1) ? $clog2(sck_div) : 1;
    localparam int msb     = flash_ctrl_pkg::word_w - 1;

    logic [presc_w-1:0]                presc;
    logic                              active;
    logic                              tail;    // Hold after last falling edge
    logic                              sck_r;
    logic [5:0]                        bits_left;
    flash_ctrl_pkg::lane_mode_t        mode_r;
    logic                              capture_r;
    logic [flash_ctrl_pkg::word_w-1:0] sr;
    logic                              tick;
    logic                              rise;
    logic                              fall;
    logic                              quad;

    assign tick = active && (presc == '0);
    assign rise = tick && !tail && !sck_r && (bits_left != '0);
    assign fall = tick && !tail && sck_r;
    assign quad = (mode_r == flash_ctrl_pkg::lane_quad);

    //////////////////////////////////////////////////
    // Prescaler, sck and bit counter

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            active    <= 1'b0;
            tail      <= 1'b0;
            sck_r     <= 1'b0;
            presc     <= '0;
            bits_left <= '0;
            mode_r    <= flash_ctrl_pkg::lane_single;
            capture_r <= 1'b0;
            job_done  <= 1'b0;
        end else begin
            job_done <= 1'b0;
            if (!active) begin
                if (job_go) begin
                    active    <= 1'b1;
                    tail      <= 1'b0;
                    presc     <= presc_w'(sck_div - 1);
                    bits_left <= job.bit_count;
                    mode_r    <= job.mode;
                    capture_r <= job.capture;
                end
            end else if (presc != '0) begin
                presc <= presc - 1'b1;
            end else begin
                presc <= presc_w'(sck_div - 1);
                if (tail) begin
                    active   <= 1'b0;
                    job_done <= 1'b1;
                end else if (sck_r) begin
                    sck_r     <= 1'b0;
                    bits_left <= bits_left - 1'b1;
                    tail      <= (bits_left == 6'd1);
                end else if (bits_left == '0) begin
                    tail <= 1'b1;   // Pause job, no clocks
                end else begin
                    sck_r <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Shift register

    always_ff @(posedge i_clk) begin
        if (!active && job_go) begin
            sr <= job.tx_data;
        end else if (rise && capture_r) begin
            sr <= quad ? {sr[msb-4:0], dq_in} : {sr[msb-1:0], dq_in[1]};
        end else if (fall && !capture_r) begin
            sr <= quad ? {sr[msb-4:0], 4'h0} : {sr[msb-1:0], 1'b0};
        end
    end

    assign sck     = sck_r;
    assign rx_data = sr;

    // WP and HOLD held high in single mode
    assign dq_out = quad ? sr[msb:msb-3] : {2'b11, 1'b0, sr[msb]};

    always_comb begin
        if (!active) begin
            dq_oe = 4'b0000;
        end else if (quad) begin
            dq_oe = capture_r ? 4'b0000 : 4'b1111;
        end else begin
            dq_oe = 4'b1101;   // Lane 1 is the flash output
        end
    end

endmodule

// ==== source/flash_sequencer.sv ====
`timescale 1ns/10ps

module flash_sequencer (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  flash_ctrl_pkg::flash_req_t         req,
    input  logic                               req_load,
    input  logic                               cont,
    input  logic                               job_done,
    input  logic [flash_ctrl_pkg::word_w-1:0]  rx_data,
    output flash_ctrl_pkg::shift_job_t         job,
    output logic                               job_go,
    output logic                               cs_n,
    output logic                               next_word,
    output logic [flash_ctrl_pkg::word_w-1:0]  rdata,
    output logic                               rd_valid,
    output logic                               wr_done,
    output logic                               busy
);

    typedef enum logic [3:0] {
        s_idle,
        s_cmd,        // Opcode and address
        s_dummy,
        s_data,
        s_wren,
        s_gap_prog,   // cs_n high before program
        s_prog_data,
        s_gap_poll,   // cs_n high before status read
        s_poll_cmd,
        s_poll_data
    } state_t;

    state_t state;

    flash_ctrl_pkg::shift_job_t cmd_job;
    flash_ctrl_pkg::shift_job_t data_job;
    flash_ctrl_pkg::shift_job_t wait_job;

    function automatic flash_ctrl_pkg::shift_job_t make_job(
        input logic [flash_ctrl_pkg::word_w-1:0] tx,
        input logic [5:0]                        count,
        input flash_ctrl_pkg::lane_mode_t        mode,
        input logic                              capture
    );
        flash_ctrl_pkg::shift_job_t j;
        j.tx_data   = tx;
        j.bit_count = count;
        j.mode      = mode;
        j.capture   = capture;
        return j;
    endfunction

    assign cmd_job  = make_job({req.opcode, req.addr}, 6'd32, flash_ctrl_pkg::lane_single, 1'b0);
    // Quad pulls 4 bits per clock
    assign data_job = make_job('0, (req.mode == flash_ctrl_pkg::lane_quad) ? 6'd8 : 6'd32,
                               req.mode, 1'b1);
    // Pause with lanes released
    assign wait_job = make_job('0, 6'd0, flash_ctrl_pkg::lane_quad, 1'b1);

    //////////////////////////////////////////////////
    // Transaction FSM

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= s_idle;
            cs_n      <= 1'b1;
            job_go    <= 1'b0;
            next_word <= 1'b0;
            rd_valid  <= 1'b0;
            wr_done   <= 1'b0;
            busy      <= 1'b0;
        end else begin
            job_go    <= 1'b0;
            next_word <= 1'b0;
            rd_valid  <= 1'b0;
            wr_done   <= 1'b0;
            case (state)
                s_idle: if (req_load) begin
                    busy   <= 1'b1;
                    cs_n   <= 1'b0;
                    job_go <= 1'b1;
                    if (req.is_write) begin
                        job   <= make_job({flash_ctrl_pkg::op_write_enable, 24'h0}, 6'd8,
                                          flash_ctrl_pkg::lane_single, 1'b0);
                        state <= s_wren;
                    end else begin
                        job   <= cmd_job;
                        state <= s_cmd;
                    end
                end
                s_wren: if (job_done) begin
                    cs_n   <= 1'b1;   // WREN latches on cs_n rise
                    job_go <= 1'b1;
                    job    <= wait_job;
                    state  <= s_gap_prog;
                end
                s_gap_prog: if (job_done) begin
                    cs_n   <= 1'b0;
                    job_go <= 1'b1;
                    job    <= cmd_job;
                    state  <= s_cmd;
                end
                s_cmd: if (job_done) begin
                    job_go <= 1'b1;
                    if (req.is_write) begin
                        job   <= make_job(req.wdata, 6'd32, flash_ctrl_pkg::lane_single, 1'b0);
                        state <= s_prog_data;
                    end else if (req.mode == flash_ctrl_pkg::lane_quad) begin
                        job   <= make_job('0, 6'(flash_ctrl_pkg::dummy_clocks),
                                          flash_ctrl_pkg::lane_single, 1'b0);
                        state <= s_dummy;
                    end else begin
                        job   <= data_job;
                        state <= s_data;
                    end
                end
                s_dummy: if (job_done) begin
                    job_go <= 1'b1;
                    job    <= data_job;
                    state  <= s_data;
                end
                s_data: if (job_done) begin
                    rdata    <= rx_data;
                    rd_valid <= 1'b1;
                    if (cont) begin
                        next_word <= 1'b1;   // Stay in the same transaction
                        job_go    <= 1'b1;
                        job       <= data_job;
                    end else begin
                        cs_n  <= 1'b1;
                        busy  <= 1'b0;
                        state <= s_idle;
                    end
                end
                s_prog_data: if (job_done) begin
                    cs_n   <= 1'b1;   // Starts the internal program
                    job_go <= 1'b1;
                    job    <= wait_job;
                    state  <= s_gap_poll;
                end
                s_gap_poll: if (job_done) begin
                    cs_n   <= 1'b0;
                    job_go <= 1'b1;
                    job    <= make_job({flash_ctrl_pkg::op_read_status, 24'h0}, 6'd8,
                                       flash_ctrl_pkg::lane_single, 1'b0);
                    state  <= s_poll_cmd;
                end
                s_poll_cmd: if (job_done) begin
                    job_go <= 1'b1;
                    job    <= make_job('0, 6'd8, flash_ctrl_pkg::lane_single, 1'b1);
                    state  <= s_poll_data;
                end
                s_poll_data: if (job_done) begin
                    cs_n <= 1'b1;
                    if (rx_data[flash_ctrl_pkg::status_busy_bit]) begin
                        job_go <= 1'b1;   // Still programming, poll again
                        job    <= wait_job;
                        state  <= s_gap_poll;
                    end else begin
                        wr_done <= 1'b1;
                        busy    <= 1'b0;
                        state   <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// ==== source/flash_request_regs.sv ====
`timescale 1ns/10ps

module flash_request_regs (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  logic                               start,
    input  logic                               quad,
    input  logic                               write,
    input  logic [flash_ctrl_pkg::addr_w-1:0]  addr,
    input  logic [flash_ctrl_pkg::word_w-1:0]  wdata,
    input  logic                               busy,
    input  logic                               next_word,
    output flash_ctrl_pkg::flash_req_t         req,
    output logic                               req_load
);

    logic [7:0] sel_opcode;
    logic       accept;

    // busy only rises with req_load, so block that cycle as well
    assign accept = start && !busy && !req_load;

    always_comb begin
        if (write) begin
            sel_opcode = flash_ctrl_pkg::op_page_program;
        end else if (quad) begin
            sel_opcode = flash_ctrl_pkg::op_quad_read;
        end else begin
            sel_opcode = flash_ctrl_pkg::op_read;
        end
    end

    //////////////////////////////////////////////////
    // Request registers

    always_ff @(posedge i_clk) begin
        if (accept) begin
            req.opcode   <= sel_opcode;
            req.addr     <= addr;
            req.wdata    <= wdata;
            req.is_write <= write;
            // Program is always single lane
            req.mode     <= (quad && !write) ? flash_ctrl_pkg::lane_quad
                                             : flash_ctrl_pkg::lane_single;
        end else if (next_word) begin
            req.addr <= req.addr + flash_ctrl_pkg::addr_w'(4);   // Next word of cont read
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            req_load <= 1'b0;
        end else begin
            req_load <= accept;
        end
    end

endmodule

// ==== source/flash_ctrl_pkg.sv ====
package flash_ctrl_pkg;

    //////////////////////////////////////////////////
    // Widths

    localparam int addr_w       = 24;
    localparam int word_w       = 32;
    localparam int dummy_clocks = 8;   // Quad output read latency

    //////////////////////////////////////////////////
    // Flash opcodes

    localparam logic [7:0] op_read         = 8'h03;
    localparam logic [7:0] op_quad_read    = 8'h6B;
    localparam logic [7:0] op_write_enable = 8'h06;
    localparam logic [7:0] op_page_program = 8'h02;
    localparam logic [7:0] op_read_status  = 8'h05;

    // Write in progress
    localparam int status_busy_bit = 0;

    //////////////////////////////////////////////////
    // Types

    typedef enum logic {
        lane_single = 1'b0,   // Out on lane 0, in on lane 1
        lane_quad   = 1'b1    // All four lanes
    } lane_mode_t;

    // Request as latched from the host
    typedef struct packed {
        logic [7:0]        opcode;
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] wdata;
        logic              is_write;
        lane_mode_t        mode;
    } flash_req_t;

    // One shift phase for the shifter
    typedef struct packed {
        logic [word_w-1:0] tx_data;     // MSB first
        logic [5:0]        bit_count;   // Rising sck edges, zero is a pause
        lane_mode_t        mode;
        logic              capture;     // Sample input lanes
    } shift_job_t;

endpackage
